// File: hw/uart_pkg.sv
// ============================
// serial side definitions
// frames are 8N1, lsb first, line idles high
// bit timing is a module parameter, not set here
// ============================

package uart_pkg;

    // one data byte on the line
    typedef logic [7:0] byte_t;

    // data bits per frame
    localparam int DATA_BITS = 8;

    // line levels of the framing bits
    localparam logic START_BIT = 1'b0;
    localparam logic STOP_BIT = 1'b1;

endpackage

// File: hw/calc_pkg.sv
// ============================
// calculator definitions
// command: ddd-ddd-ooo plus newline, 12 bytes
// reply: a, b, op code, result hi, result lo, newline
// operands wrap modulo 256
// ============================

package calc_pkg;

    typedef logic [7:0] operand_t;
    typedef logic [15:0] result_t;

    // codes are sent back as the third reply byte
    typedef enum logic [2:0] {
        OP_NONE = 3'd0,
        OP_ADD  = 3'd1,
        OP_SUB  = 3'd2,
        OP_MUL  = 3'd3,
        OP_DIV  = 3'd4
    } op_e;

    localparam int CMD_LEN = 12;
    localparam int REPLY_LEN = 6;

    // ascii of the command format
    localparam logic [7:0] ASCII_DASH = 8'h2d;
    localparam logic [7:0] ASCII_NL = 8'h0a;
    localparam logic [7:0] ASCII_ZERO = 8'h30;

    // operation words, first letter in the top byte
    localparam logic [23:0] WORD_ADD = "add";
    localparam logic [23:0] WORD_SUB = "sub";
    localparam logic [23:0] WORD_MUL = "mul";
    localparam logic [23:0] WORD_DIV = "div";

endpackage

// File: hw/uart_rx.sv
// ============================
// uart receiver, 8N1
// clks_per_bit must be 4 or more
// byte_valid pulses one cycle, byte_data holds until next frame
// frames with a low stop bit are dropped
// ============================
`timescale 1ns/1ps

module uart_rx #(
    parameter int clks_per_bit = 16
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            rx,
    output logic            byte_valid,
    output uart_pkg::byte_t byte_data
);

    localparam int CNT_W = $clog2(clks_per_bit);
    localparam int BIT_W = $clog2(uart_pkg::DATA_BITS);

    typedef logic [CNT_W-1:0] cnt_t;
    typedef logic [BIT_W-1:0] bit_idx_t;
    typedef enum logic [1:0] {S_IDLE, S_START, S_DATA, S_STOP} state_e;

    state_e          state_q;
    cnt_t            cnt_q;
    bit_idx_t        bit_q;
    logic            rx_meta;
    logic            rx_sync;
    logic            valid_q;
    uart_pkg::byte_t shift_q;
    logic            bit_end;

    // full bit time elapsed
    assign bit_end = (cnt_q == cnt_t'(clks_per_bit - 1));

    // two flop synchronizer, idles high
    always_ff @(posedge clk) begin
        if (reset) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= S_IDLE;
            cnt_q   <= '0;
            bit_q   <= '0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= 1'b0;
            case (state_q)
                S_IDLE: begin
                    cnt_q <= '0;
                    if (rx_sync == uart_pkg::START_BIT) begin
                        state_q <= S_START;
                    end
                end
                S_START: begin
                    // confirm start at half a bit, glitches go back to idle
                    if (cnt_q == cnt_t'(clks_per_bit / 2 - 1)) begin
                        cnt_q   <= '0;
                        bit_q   <= '0;
                        state_q <= (rx_sync == uart_pkg::START_BIT) ? S_DATA : S_IDLE;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                S_DATA: begin
                    if (bit_end) begin
                        cnt_q <= '0;
                        if (bit_q == bit_idx_t'(uart_pkg::DATA_BITS - 1)) begin
                            state_q <= S_STOP;
                        end else begin
                            bit_q <= bit_q + 1'b1;
                        end
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                S_STOP: begin
                    if (bit_end) begin
                        valid_q <= (rx_sync == uart_pkg::STOP_BIT);
                        state_q <= S_IDLE;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // lsb first, shift in from the top
    always_ff @(posedge clk) begin
        if (state_q == S_DATA && bit_end) begin
            shift_q <= {rx_sync, shift_q[uart_pkg::DATA_BITS-1:1]};
        end
    end

    assign byte_valid = valid_q;
    assign byte_data  = shift_q;

endmodule

// File: hw/uart_tx.sv
// ============================
// uart transmitter, 8N1
// tx_start is ignored while a frame is in flight
// tx_done pulses in the last cycle of the stop bit
// ============================
`timescale 1ns/1ps

module uart_tx #(
    parameter int clks_per_bit = 16
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            tx_start,
    input  uart_pkg::byte_t tx_byte,
    output logic            tx_done,
    output logic            tx
);

    localparam int CNT_W = $clog2(clks_per_bit);
    localparam int BIT_W = $clog2(uart_pkg::DATA_BITS);

    typedef logic [CNT_W-1:0] cnt_t;
    typedef logic [BIT_W-1:0] bit_idx_t;
    typedef enum logic [1:0] {S_IDLE, S_START, S_DATA, S_STOP} state_e;

    state_e          state_q;
    cnt_t            cnt_q;
    bit_idx_t        bit_q;
    logic            tx_q;
    uart_pkg::byte_t shift_q;
    logic            bit_end;

    assign bit_end = (cnt_q == cnt_t'(clks_per_bit - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= S_IDLE;
            cnt_q   <= '0;
            bit_q   <= '0;
            tx_q    <= uart_pkg::STOP_BIT;
        end else begin
            // bit timer runs in every state but idle
            cnt_q <= (state_q == S_IDLE || bit_end) ? '0 : cnt_q + 1'b1;
            case (state_q)
                S_IDLE: begin
                    if (tx_start) begin
                        tx_q    <= uart_pkg::START_BIT;
                        state_q <= S_START;
                    end
                end
                S_START: begin
                    if (bit_end) begin
                        tx_q    <= shift_q[0];
                        bit_q   <= '0;
                        state_q <= S_DATA;
                    end
                end
                S_DATA: begin
                    if (bit_end) begin
                        if (bit_q == bit_idx_t'(uart_pkg::DATA_BITS - 1)) begin
                            tx_q    <= uart_pkg::STOP_BIT;
                            state_q <= S_STOP;
                        end else begin
                            // shift_q moves on this same edge
                            tx_q  <= shift_q[1];
                            bit_q <= bit_q + 1'b1;
                        end
                    end
                end
                S_STOP: begin
                    if (bit_end) begin
                        state_q <= S_IDLE;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == S_IDLE && tx_start) begin
            shift_q <= tx_byte;
        end else if (state_q == S_DATA && bit_end) begin
            shift_q <= shift_q >> 1;
        end
    end

    assign tx_done = (state_q == S_STOP) && bit_end;
    assign tx      = tx_q;

endmodule

// File: hw/calc_decode.sv
// ============================
// command line parser
// format ddd-ddd-ooo then newline, checked per byte
// any newline restarts the line, bad lines are dropped
// bytes are discarded while a command is pending
// ============================
`timescale 1ns/1ps

module calc_decode (
    input  logic               clk,
    input  logic               reset,
    input  logic               byte_valid,
    input  uart_pkg::byte_t    byte_data,
    output logic               cmd_req,
    input  logic               cmd_ack,
    output calc_pkg::operand_t operand_a,
    output calc_pkg::operand_t operand_b,
    output calc_pkg::op_e      op
);

    localparam int IDX_W = $clog2(calc_pkg::CMD_LEN);

    typedef logic [IDX_W-1:0] idx_t;
    typedef enum logic [1:0] {D_IDLE, D_REQ, D_RELEASE} state_e;

    state_e             state_q;
    idx_t               idx_q;
    logic               err_q;
    calc_pkg::operand_t num_a_q;
    calc_pkg::operand_t num_b_q;
    logic [23:0]        word_q;
    calc_pkg::operand_t digit;
    logic               is_digit;
    logic               is_nl;
    logic               pos_ok;
    logic               last_pos;

    assign digit    = byte_data - calc_pkg::ASCII_ZERO;
    assign is_digit = (byte_data >= calc_pkg::ASCII_ZERO) &&
                      (byte_data <= calc_pkg::ASCII_ZERO + 8'd9);
    assign is_nl    = (byte_data == calc_pkg::ASCII_NL);
    assign last_pos = (idx_q == idx_t'(calc_pkg::CMD_LEN - 1));

    // expected byte class per position, newline handled apart
    always_comb begin
        case (idx_q)
            3, 7:     pos_ok = (byte_data == calc_pkg::ASCII_DASH);
            8, 9, 10: pos_ok = 1'b1;
            11:       pos_ok = 1'b0;
            default:  pos_ok = is_digit;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= D_IDLE;
            idx_q   <= '0;
            err_q   <= 1'b0;
        end else begin
            case (state_q)
                D_IDLE: begin
                    if (byte_valid && is_nl) begin
                        idx_q <= '0;
                        err_q <= 1'b0;
                        if (last_pos && !err_q) begin
                            state_q <= D_REQ;
                        end
                    end else if (byte_valid) begin
                        if (!pos_ok) begin
                            err_q <= 1'b1;
                        end
                        // overlong lines park on the last slot
                        if (!last_pos) begin
                            idx_q <= idx_q + 1'b1;
                        end
                    end
                end
                D_REQ: begin
                    if (cmd_ack) begin
                        state_q <= D_RELEASE;
                    end
                end
                D_RELEASE: begin
                    if (!cmd_ack) begin
                        state_q <= D_IDLE;
                    end
                end
                default: state_q <= D_IDLE;
            endcase
        end
    end

    // number accumulation wraps modulo 256
    always_ff @(posedge clk) begin
        if (state_q == D_IDLE && byte_valid) begin
            case (idx_q)
                0:        num_a_q <= digit;
                1, 2:     num_a_q <= num_a_q * 8'd10 + digit;
                4:        num_b_q <= digit;
                5, 6:     num_b_q <= num_b_q * 8'd10 + digit;
                8, 9, 10: word_q <= {word_q[15:0], byte_data};
                default:  word_q <= word_q;
            endcase
        end
    end

    always_comb begin
        case (word_q)
            calc_pkg::WORD_ADD: op = calc_pkg::OP_ADD;
            calc_pkg::WORD_SUB: op = calc_pkg::OP_SUB;
            calc_pkg::WORD_MUL: op = calc_pkg::OP_MUL;
            calc_pkg::WORD_DIV: op = calc_pkg::OP_DIV;
            default:            op = calc_pkg::OP_NONE;
        endcase
    end

    assign cmd_req   = (state_q == D_REQ);
    assign operand_a = num_a_q;
    assign operand_b = num_b_q;

endmodule

// File: hw/calc_execute.sv
// ============================
// four operation ALU
// add, sub, mul in one cycle, div takes 8 steps
// sub wraps mod 65536, div by zero gives 16'hffff
// new commands wait until the result side releases
// ============================
`timescale 1ns/1ps

module calc_execute (
    input  logic               clk,
    input  logic               reset,
    input  logic               cmd_req,
    output logic               cmd_ack,
    input  calc_pkg::operand_t operand_a,
    input  calc_pkg::operand_t operand_b,
    input  calc_pkg::op_e      op,
    output logic               res_req,
    input  logic               res_ack,
    output calc_pkg::operand_t res_a,
    output calc_pkg::operand_t res_b,
    output calc_pkg::op_e      res_op,
    output calc_pkg::result_t  res_value
);

    localparam int OP_W = $bits(calc_pkg::operand_t);

    typedef logic [$clog2(OP_W)-1:0] step_t;
    typedef enum logic [1:0] {E_IDLE, E_DIVIDE, E_REPORT, E_WAIT_REL} state_e;

    state_e             state_q;
    logic               ack_q;
    step_t              step_q;
    calc_pkg::operand_t rem_q;
    logic [OP_W:0]      shifted;
    logic               take;
    logic               accept;

    assign accept = (state_q == E_IDLE) && cmd_req && !ack_q;

    // restoring step, dividend shifts out of the low result byte
    assign shifted = {rem_q, res_value[OP_W-1]};
    assign take    = (shifted >= {1'b0, res_b});

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= E_IDLE;
            ack_q   <= 1'b0;
            step_q  <= '0;
        end else begin
            if (accept) begin
                ack_q <= 1'b1;
            end else if (!cmd_req) begin
                ack_q <= 1'b0;
            end
            case (state_q)
                E_IDLE: begin
                    step_q <= '0;
                    if (accept) begin
                        state_q <= (op == calc_pkg::OP_DIV && operand_b != '0) ?
                                   E_DIVIDE : E_REPORT;
                    end
                end
                E_DIVIDE: begin
                    step_q <= step_q + 1'b1;
                    if (step_q == step_t'(OP_W - 1)) begin
                        state_q <= E_REPORT;
                    end
                end
                E_REPORT: begin
                    if (res_ack) begin
                        state_q <= E_WAIT_REL;
                    end
                end
                E_WAIT_REL: begin
                    if (!res_ack) begin
                        state_q <= E_IDLE;
                    end
                end
                default: state_q <= E_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            res_a  <= operand_a;
            res_b  <= operand_b;
            res_op <= op;
            rem_q  <= '0;
            case (op)
                calc_pkg::OP_ADD: res_value <= operand_a + operand_b;
                calc_pkg::OP_SUB: res_value <= operand_a - operand_b;
                calc_pkg::OP_MUL: res_value <= operand_a * operand_b;
                calc_pkg::OP_DIV: res_value <= (operand_b == '0) ? 16'hffff : {8'h00, operand_a};
                default:          res_value <= '0;
            endcase
        end else if (state_q == E_DIVIDE) begin
            res_value[OP_W-1:0] <= {res_value[OP_W-2:0], take};
            rem_q <= take ? calc_pkg::operand_t'(shifted - {1'b0, res_b}) : shifted[OP_W-1:0];
        end
    end

    assign cmd_ack = ack_q;
    assign res_req = (state_q == E_REPORT);

endmodule

// File: hw/calc_result.sv
// ============================
// reply buffer and sender
// six bytes back to back, newline last
// acks a result only when the line is free
// ============================
`timescale 1ns/1ps

module calc_result (
    input  logic               clk,
    input  logic               reset,
    input  logic               res_req,
    output logic               res_ack,
    input  calc_pkg::operand_t res_a,
    input  calc_pkg::operand_t res_b,
    input  calc_pkg::op_e      res_op,
    input  calc_pkg::result_t  res_value,
    output logic               tx_start,
    output uart_pkg::byte_t    tx_byte,
    input  logic               tx_done
);

    typedef logic [$clog2(calc_pkg::REPLY_LEN)-1:0] idx_t;
    typedef enum logic [1:0] {R_IDLE, R_LOAD, R_SEND} state_e;

    state_e          state_q;
    idx_t            idx_q;
    logic            ack_q;
    logic            start_q;
    logic            take;
    uart_pkg::byte_t reply_q [calc_pkg::REPLY_LEN];

    assign take = (state_q == R_IDLE) && res_req && !ack_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= R_IDLE;
            idx_q   <= '0;
            ack_q   <= 1'b0;
            start_q <= 1'b0;
        end else begin
            start_q <= 1'b0;
            if (take) begin
                ack_q <= 1'b1;
            end else if (!res_req) begin
                ack_q <= 1'b0;
            end
            case (state_q)
                R_IDLE: begin
                    if (take) begin
                        idx_q   <= '0;
                        state_q <= R_LOAD;
                    end
                end
                R_LOAD: begin
                    // first byte goes out the cycle after the ack
                    start_q <= 1'b1;
                    state_q <= R_SEND;
                end
                R_SEND: begin
                    if (tx_done) begin
                        if (idx_q == idx_t'(calc_pkg::REPLY_LEN - 1)) begin
                            state_q <= R_IDLE;
                        end else begin
                            idx_q   <= idx_q + 1'b1;
                            start_q <= 1'b1;
                        end
                    end
                end
                default: state_q <= R_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            reply_q[0] <= res_a;
            reply_q[1] <= res_b;
            reply_q[2] <= uart_pkg::byte_t'(res_op);
            reply_q[3] <= res_value[15:8];
            reply_q[4] <= res_value[7:0];
            reply_q[5] <= calc_pkg::ASCII_NL;
        end
    end

    assign res_ack  = ack_q;
    assign tx_start = start_q;
    assign tx_byte  = reply_q[idx_q];

endmodule

// File: hw/uart_calc_top.sv
// ============================
// uart calculator top
// rx and tx idle high, 8N1
// clks_per_bit sets the baud rate, 4 or more
// ============================
`timescale 1ns/1ps

module uart_calc_top #(
    parameter int clks_per_bit = 16
) (
    input  logic clk,
    input  logic reset,
    input  logic rx,
    output logic tx
);

    logic               byte_valid;
    uart_pkg::byte_t    byte_data;
    logic               cmd_req;
    logic               cmd_ack;
    calc_pkg::operand_t operand_a;
    calc_pkg::operand_t operand_b;
    calc_pkg::op_e      op;
    logic               res_req;
    logic               res_ack;
    calc_pkg::operand_t res_a;
    calc_pkg::operand_t res_b;
    calc_pkg::op_e      res_op;
    calc_pkg::result_t  res_value;
    logic               tx_start;
    uart_pkg::byte_t    tx_byte;
    logic               tx_done;

    uart_rx #(
        .clks_per_bit(clks_per_bit)
    ) i_uart_rx (
        .clk        (clk),
        .reset      (reset),
        .rx         (rx),
        .byte_valid (byte_valid),
        .byte_data  (byte_data)
    );

    calc_decode i_calc_decode (
        .clk        (clk),
        .reset      (reset),
        .byte_valid (byte_valid),
        .byte_data  (byte_data),
        .cmd_req    (cmd_req),
        .cmd_ack    (cmd_ack),
        .operand_a  (operand_a),
        .operand_b  (operand_b),
        .op         (op)
    );

    calc_execute i_calc_execute (
        .clk        (clk),
        .reset      (reset),
        .cmd_req    (cmd_req),
        .cmd_ack    (cmd_ack),
        .operand_a  (operand_a),
        .operand_b  (operand_b),
        .op         (op),
        .res_req    (res_req),
        .res_ack    (res_ack),
        .res_a      (res_a),
        .res_b      (res_b),
        .res_op     (res_op),
        .res_value  (res_value)
    );

    calc_result i_calc_result (
        .clk        (clk),
        .reset      (reset),
        .res_req    (res_req),
        .res_ack    (res_ack),
        .res_a      (res_a),
        .res_b      (res_b),
        .res_op     (res_op),
        .res_value  (res_value),
        .tx_start   (tx_start),
        .tx_byte    (tx_byte),
        .tx_done    (tx_done)
    );

    uart_tx #(
        .clks_per_bit(clks_per_bit)
    ) i_uart_tx (
        .clk        (clk),
        .reset      (reset),
        .tx_start   (tx_start),
        .tx_byte    (tx_byte),
        .tx_done    (tx_done),
        .tx         (tx)
    );

endmodule

// File: dv/uart_calc_tb.sv
// ==============================
// testbench for uart_calc_top
// commands and expected replies come from dv/uart_calc_golden.txt
// a golden reply of six 00 bytes means no reply is expected
// serial timing assumes clks_per_bit = 16 on both sides
// ==============================
`timescale 1ns/1ps

module uart_calc_tb;

    localparam int clks_per_bit = 16;
    localparam int line_bytes = calc_pkg::CMD_LEN + calc_pkg::REPLY_LEN;
    localparam int max_lines = 32;
    // whole command plus 20 bit times of silence
    localparam int first_limit = (calc_pkg::CMD_LEN * 10 + 20) * clks_per_bit;

    logic clk;
    logic reset;
    logic rx;
    logic tx;

    uart_pkg::byte_t golden_mem [max_lines * line_bytes];
    uart_pkg::byte_t reply_bytes [calc_pkg::REPLY_LEN];
    logic [31:0]     lfsr_q;
    int              value_errors;
    int              proto_errors;
    int              cmd_num;
    logic            got_reply;

    uart_calc_top #(
        .clks_per_bit(clks_per_bit)
    ) i_dut (
        .clk   (clk),
        .reset (reset),
        .rx    (rx),
        .tx    (tx)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // galois lfsr with taps of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one lfsr step per bit
    task automatic draw_bits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            val = (val << 1) | int'(lfsr_q[0]);
            lfsr_q = lfsr_next(lfsr_q);
        end
    endtask

    task automatic check_line(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            value_errors++;
            $display("ERROR %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_operand(input string name, input calc_pkg::operand_t got,
                                 input calc_pkg::operand_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("ERROR %s (command %0d): got %h, expected %h", name, cmd_num, got, exp);
        end
    endtask

    task automatic check_op(input string name, input calc_pkg::op_e got,
                            input calc_pkg::op_e exp);
        if (got !== exp) begin
            value_errors++;
            $display("ERROR %s (command %0d): got %h, expected %h", name, cmd_num, got, exp);
        end
    endtask

    task automatic check_result(input string name, input calc_pkg::result_t got,
                                input calc_pkg::result_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("ERROR %s (command %0d): got %h, expected %h", name, cmd_num, got, exp);
        end
    endtask

    task automatic check_byte(input string name, input uart_pkg::byte_t got,
                              input uart_pkg::byte_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("ERROR %s (command %0d): got %h, expected %h", name, cmd_num, got, exp);
        end
    endtask

    // starts on a falling edge and holds each bit one bit time
    task automatic send_byte(input uart_pkg::byte_t b);
        rx = uart_pkg::START_BIT;
        repeat (clks_per_bit) @(negedge clk);
        for (int i = 0; i < uart_pkg::DATA_BITS; i++) begin
            rx = b[i];
            repeat (clks_per_bit) @(negedge clk);
        end
        rx = uart_pkg::STOP_BIT;
        repeat (clks_per_bit) @(negedge clk);
    endtask

    task automatic send_command(input int base);
        for (int i = 0; i < calc_pkg::CMD_LEN; i++) begin
            send_byte(golden_mem[base + i]);
        end
    endtask

    // level search on tx bounded by limit cycles
    task automatic wait_start(input int limit, output logic found);
        int n;
        found = 1'b0;
        n = 0;
        while (!found && n < limit) begin
            @(negedge clk);
            n++;
            if (tx === uart_pkg::START_BIT) begin
                found = 1'b1;
            end
        end
    endtask

    // entered just after the start edge and samples each bit at its middle
    task automatic receive_byte(output uart_pkg::byte_t b);
        repeat (clks_per_bit / 2) @(negedge clk);
        if (tx !== uart_pkg::START_BIT) begin
            proto_errors++;
            $display("start bit on tx was not low at mid-bit (command %0d)", cmd_num);
        end
        for (int i = 0; i < uart_pkg::DATA_BITS; i++) begin
            repeat (clks_per_bit) @(negedge clk);
            b[i] = tx;
        end
        repeat (clks_per_bit) @(negedge clk);
        if (tx !== uart_pkg::STOP_BIT) begin
            proto_errors++;
            $display("stop bit on tx was not high (command %0d)", cmd_num);
        end
    endtask

    task automatic collect_reply(input int limit, output logic got_any);
        logic            found;
        uart_pkg::byte_t b;
        got_any = 1'b0;
        wait_start(limit, found);
        if (!found) begin
            return;
        end
        got_any = 1'b1;
        for (int k = 0; k < calc_pkg::REPLY_LEN; k++) begin
            // frames follow back to back
            if (k > 0) begin
                wait_start(2 * clks_per_bit, found);
                if (!found) begin
                    proto_errors++;
                    $display("reply to command %0d stopped after %0d bytes", cmd_num, k);
                    return;
                end
            end
            receive_byte(b);
            reply_bytes[k] = b;
        end
    endtask

    initial begin
        int  base;
        int  gap;
        logic expect_reply;
        rx = 1'b1;
        reset = 1'b1;
        lfsr_q = 32'h2062;
        value_errors = 0;
        proto_errors = 0;
        cmd_num = 0;
        got_reply = 1'b0;
        $readmemh("dv/uart_calc_golden.txt", golden_mem);

        // tx must idle high through reset and before any command
        repeat (4) begin
            @(negedge clk);
            check_line("tx during reset", tx, 1'b1);
        end
        reset = 1'b0;
        repeat (4 * clks_per_bit) begin
            @(negedge clk);
            check_line("tx before first command", tx, 1'b1);
        end

        if ($isunknown(golden_mem[0])) begin
            proto_errors++;
            $display("golden file holds no commands");
        end

        while (cmd_num < max_lines && !$isunknown(golden_mem[cmd_num * line_bytes])) begin
            base = cmd_num * line_bytes;
            draw_bits(2, gap);
            repeat (gap * clks_per_bit) @(negedge clk);
            expect_reply = 1'b0;
            for (int i = 0; i < calc_pkg::REPLY_LEN; i++) begin
                if (golden_mem[base + calc_pkg::CMD_LEN + i] != 8'h00) begin
                    expect_reply = 1'b1;
                end
            end
            // reply may start before the newline stop bit ends
            fork
                send_command(base);
                collect_reply(first_limit, got_reply);
            join
            if (expect_reply && !got_reply) begin
                proto_errors++;
                $display("no reply to command %0d before the timeout", cmd_num);
            end else if (!expect_reply && got_reply) begin
                proto_errors++;
                $display("reply sent for malformed command %0d", cmd_num);
            end else if (got_reply) begin
                check_operand("reply number one", reply_bytes[0], golden_mem[base + 12]);
                check_operand("reply number two", reply_bytes[1], golden_mem[base + 13]);
                check_op("reply op code", calc_pkg::op_e'(reply_bytes[2][2:0]),
                         calc_pkg::op_e'(golden_mem[base + 14][2:0]));
                if (reply_bytes[2][7:3] !== 5'd0) begin
                    value_errors++;
                    $display("ERROR reply op code msbs (command %0d): got %h, expected %h",
                             cmd_num, reply_bytes[2][7:3], 5'd0);
                end
                check_result("reply result", {reply_bytes[3], reply_bytes[4]},
                             {golden_mem[base + 15], golden_mem[base + 16]});
                check_byte("reply newline", reply_bytes[5], golden_mem[base + 17]);
            end
            cmd_num++;
        end

        $display("%0d commands, %0d value errors, %0d protocol errors",
                 cmd_num, value_errors, proto_errors);
        if (value_errors == 0 && proto_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: dv/uart_calc_golden.txt
// columns: 12 command bytes, then reply bytes a, b, op code, result hi, result lo, newline
// a reply of six 00 bytes marks a malformed command that must get no reply
31 32 33 2d 30 34 35 2d 61 64 64 0a  7b 2d 01 00 a8 0a  // 123-045-add
32 30 30 2d 30 35 30 2d 73 75 62 0a  c8 32 02 00 96 0a  // 200-050-sub
30 30 35 2d 30 31 30 2d 73 75 62 0a  05 0a 02 ff fb 0a  // 005-010-sub wraps
32 35 35 2d 32 35 35 2d 6d 75 6c 0a  ff ff 03 fe 01 0a  // 255-255-mul
31 30 30 2d 30 30 37 2d 64 69 76 0a  64 07 04 00 0e 0a  // 100-007-div
30 34 32 2d 30 30 30 2d 64 69 76 0a  2a 00 04 ff ff 0a  // 042-000-div by zero
30 31 32 2d 30 33 34 2d 78 79 7a 0a  0c 22 00 00 00 0a  // 012-034-xyz unknown
33 30 30 2d 39 39 39 2d 61 64 64 0a  2c e7 01 01 13 0a  // 300-999-add mod 256
30 31 32 2b 30 33 34 2d 61 64 64 0a  00 00 00 00 00 00  // 012+034-add bad dash
30 37 37 2d 30 31 31 2d 6d 75 6c 0a  4d 0b 03 03 4f 0a  // 077-011-mul
30 61 35 2d 30 31 30 2d 73 75 62 0a  00 00 00 00 00 00  // 0a5-010-sub non-digit
32 35 30 2d 30 31 30 2d 64 69 76 0a  fa 0a 04 00 19 0a  // 250-010-div
32 35 35 2d 30 30 31 2d 61 64 64 0a  ff 01 01 01 00 0a  // 255-001-add
31 32 38 2d 32 35 35 2d 64 69 76 0a  80 ff 04 00 00 0a  // 128-255-div

// File: uart_calc.f
hw/uart_pkg.sv
hw/calc_pkg.sv
hw/uart_rx.sv
hw/uart_tx.sv
hw/calc_decode.sv
hw/calc_execute.sv
hw/calc_result.sv
hw/uart_calc_top.sv
dv/uart_calc_tb.sv
